// ==== src.f ====
src/uce_pkg.sv
src/uce_req_issuer.sv
src/uce_resp_fifo.sv
src/uce_fill_writer.sv
src/uce_top.sv
dv/uce_sva.sv
dv/uce_checker.sv
dv/uce_tb.sv

// ==== dv/uce_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module uce_tb
  import uce_pkg::*;
();

  localparam int LIGHT_REQS  = 12;
  localparam int DIRECT_REQS = 5;
  localparam int HEAVY_REQS  = 12;
  localparam int CYCLE_LIMIT = 200 * (LIGHT_REQS + DIRECT_REQS + HEAVY_REQS);

  typedef struct packed {
    mem_op_e               op;
    logic [ADDR_WIDTH-1:0] addr;
    logic [WAY_WIDTH-1:0]  way;
    logic [DATA_WIDTH-1:0] data;
  } mem_resp_t;

  logic                   clk_i;
  logic                   reset_i;
  logic                   cache_req_v_i;
  req_type_e              cache_req_type_i;
  logic [ADDR_WIDTH-1:0]  cache_req_addr_i;
  logic [WAY_WIDTH-1:0]   cache_req_way_i;
  logic [DATA_WIDTH-1:0]  cache_req_data_i;
  logic                   cache_req_yumi_o;
  logic                   cache_req_busy_o;
  logic                   cache_req_complete_o;
  logic                   cache_req_critical_o;
  logic                   cache_req_credits_full_o;
  logic                   cache_req_credits_empty_o;
  logic [DATA_WIDTH-1:0]  cache_req_uc_data_o;
  logic                   mem_cmd_v_o;
  mem_op_e                mem_cmd_op_o;
  logic [ADDR_WIDTH-1:0]  mem_cmd_addr_o;
  logic [WAY_WIDTH-1:0]   mem_cmd_way_o;
  logic [DATA_WIDTH-1:0]  mem_cmd_data_o;
  logic                   mem_cmd_ready_i;
  logic                   mem_resp_v_i;
  mem_op_e                mem_resp_op_i;
  logic [ADDR_WIDTH-1:0]  mem_resp_addr_i;
  logic [WAY_WIDTH-1:0]   mem_resp_way_i;
  logic [DATA_WIDTH-1:0]  mem_resp_data_i;
  logic                   mem_resp_yumi_o;
  logic                   data_mem_pkt_v_o;
  logic [INDEX_WIDTH-1:0] data_mem_pkt_index_o;
  logic [WAY_WIDTH-1:0]   data_mem_pkt_way_o;
  logic [BEAT_WIDTH-1:0]  data_mem_pkt_beat_o;
  logic [DATA_WIDTH-1:0]  data_mem_pkt_data_o;
  logic                   data_mem_pkt_yumi_i;
  logic                   tag_mem_pkt_v_o;
  logic [INDEX_WIDTH-1:0] tag_mem_pkt_index_o;
  logic [WAY_WIDTH-1:0]   tag_mem_pkt_way_o;
  logic [TAG_WIDTH-1:0]   tag_mem_pkt_tag_o;
  logic                   tag_mem_pkt_yumi_i;

  int stall_pct;
  int cycle_count;
  int error_count;
  int check_count;

  // memory words that stores have written, by word address
  logic [DATA_WIDTH-1:0] mem_words [logic [ADDR_WIDTH-3:0]];
  mem_resp_t             resp_q [$];

  uce_top uce_top_inst (.*);

  uce_checker uce_checker_inst (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .req_yumi_i      (cache_req_yumi_o),
    .req_type_i      (cache_req_type_i),
    .req_addr_i      (cache_req_addr_i),
    .req_way_i       (cache_req_way_i),
    .req_data_i      (cache_req_data_i),
    .cmd_v_i         (mem_cmd_v_o),
    .cmd_ready_i     (mem_cmd_ready_i),
    .cmd_op_i        (mem_cmd_op_o),
    .cmd_addr_i      (mem_cmd_addr_o),
    .cmd_way_i       (mem_cmd_way_o),
    .cmd_data_i      (mem_cmd_data_o),
    .resp_v_i        (mem_resp_v_i),
    .resp_yumi_i     (mem_resp_yumi_o),
    .dpkt_v_i        (data_mem_pkt_v_o),
    .dpkt_index_i    (data_mem_pkt_index_o),
    .dpkt_way_i      (data_mem_pkt_way_o),
    .dpkt_beat_i     (data_mem_pkt_beat_o),
    .dpkt_data_i     (data_mem_pkt_data_o),
    .dpkt_yumi_i     (data_mem_pkt_yumi_i),
    .tpkt_index_i    (tag_mem_pkt_index_o),
    .tpkt_way_i      (tag_mem_pkt_way_o),
    .tpkt_tag_i      (tag_mem_pkt_tag_o),
    .tpkt_yumi_i     (tag_mem_pkt_yumi_i),
    .critical_i      (cache_req_critical_o),
    .complete_i      (cache_req_complete_o),
    .uc_data_i       (cache_req_uc_data_o),
    .credits_full_i  (cache_req_credits_full_o),
    .credits_empty_i (cache_req_credits_empty_o),
    .error_count_o   (error_count),
    .check_count_o   (check_count)
  );

  initial
  begin
    clk_i = 1'b0;
    forever
      #5 clk_i = ~clk_i;
  end

  function automatic logic [DATA_WIDTH-1:0] memory_read(input logic [ADDR_WIDTH-1:0] addr);
    if (mem_words.exists(addr[ADDR_WIDTH-1:2]))
      return mem_words[addr[ADDR_WIDTH-1:2]];
    return {addr ^ 16'h9e37, ~addr};
  endfunction

  // holds the request until the issuer takes it
  task automatic send_request(input req_type_e req_type, input logic [ADDR_WIDTH-1:0] addr,
                              input logic [WAY_WIDTH-1:0] way,
                              input logic [DATA_WIDTH-1:0] data);
    cache_req_v_i    <= 1'b1;
    cache_req_type_i <= req_type;
    cache_req_addr_i <= addr;
    cache_req_way_i  <= way;
    cache_req_data_i <= data;
    @(posedge clk_i);
    while (!cache_req_yumi_o)
      @(posedge clk_i);
  endtask

  task automatic send_random_request();
    req_type_e             req_type;
    logic [ADDR_WIDTH-1:0] addr;
    req_type = req_type_e'($urandom % 3);
    // a small window so that loads often meet earlier stores
    addr = ADDR_WIDTH'($urandom % 256) + 16'h2400;
    if (req_type != e_miss_load)
      addr[1:0] = 2'b00;
    send_request(req_type, addr, WAY_WIDTH'($urandom), DATA_WIDTH'($urandom));
  endtask

  // memory and cache memories, with random back-pressure on every handshake
  always @(posedge clk_i)
  begin
    if (reset_i)
    begin
      resp_q.delete();
      mem_cmd_ready_i     <= 1'b0;
      mem_resp_v_i        <= 1'b0;
      data_mem_pkt_yumi_i <= 1'b0;
      tag_mem_pkt_yumi_i  <= 1'b0;
    end
    else
    begin
      if (mem_resp_v_i && mem_resp_yumi_o)
        void'(resp_q.pop_front());
      if (mem_cmd_v_o && mem_cmd_ready_i)
      begin
        if (mem_cmd_op_o == e_mem_uc_wr)
          mem_words[mem_cmd_addr_o[ADDR_WIDTH-1:2]] = mem_cmd_data_o;
        resp_q.push_back('{mem_cmd_op_o, mem_cmd_addr_o, mem_cmd_way_o,
                           memory_read(mem_cmd_addr_o)});
      end
      mem_cmd_ready_i     <= ($urandom % 100) >= stall_pct;
      data_mem_pkt_yumi_i <= ($urandom % 100) >= stall_pct;
      tag_mem_pkt_yumi_i  <= ($urandom % 100) >= stall_pct;
      if (resp_q.size() > 0)
      begin
        mem_resp_v_i    <= ($urandom % 100) >= stall_pct;
        mem_resp_op_i   <= resp_q[0].op;
        mem_resp_addr_i <= resp_q[0].addr;
        mem_resp_way_i  <= resp_q[0].way;
        mem_resp_data_i <= resp_q[0].data;
      end
      else
        mem_resp_v_i <= 1'b0;
    end
  end

  always @(posedge clk_i)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("checks: %0d, errors: %0d, assertion failures: %0d", check_count, error_count,
               uce_top_inst.uce_sva_inst.failure_count);
      $display("Test failed");
      $finish;
    end
  end

  initial
  begin
    void'($urandom(32'h4f46_b40a));
    stall_pct           <= 20;
    reset_i             <= 1'b1;
    cache_req_v_i       <= 1'b0;
    cache_req_type_i    <= e_miss_load;
    cache_req_addr_i    <= '0;
    cache_req_way_i     <= '0;
    cache_req_data_i    <= '0;
    mem_cmd_ready_i     <= 1'b0;
    mem_resp_v_i        <= 1'b0;
    mem_resp_op_i       <= e_mem_rd;
    mem_resp_addr_i     <= '0;
    mem_resp_way_i      <= '0;
    mem_resp_data_i     <= '0;
    data_mem_pkt_yumi_i <= 1'b0;
    tag_mem_pkt_yumi_i  <= 1'b0;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);

    repeat (LIGHT_REQS) send_random_request();

    // store, load it back, then miss on its block so the stored word is the last beat
    send_request(e_uc_store, 16'h2468, 1'b0, 32'hcafe_f00d);
    send_request(e_uc_load, 16'h2468, 1'b0, '0);
    send_request(e_miss_load, 16'h246c, 1'b1, '0);
    send_request(e_uc_store, 16'h2468, 1'b0, 32'h1357_9bdf);
    send_request(e_uc_load, 16'h2468, 1'b1, '0);

    stall_pct <= 70;
    repeat (HEAVY_REQS) send_random_request();
    cache_req_v_i <= 1'b0;

    @(posedge clk_i);
    while (cache_req_busy_o || !cache_req_credits_empty_o)
      @(posedge clk_i);
    repeat (5) @(posedge clk_i);

    $display("checks: %0d, errors: %0d, assertion failures: %0d", check_count, error_count,
             uce_top_inst.uce_sva_inst.failure_count);
    if (error_count == 0 && uce_top_inst.uce_sva_inst.failure_count == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/uce_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module uce_checker
  import uce_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   reset_i,
  input  wire logic                   req_yumi_i,
  input  wire req_type_e              req_type_i,
  input  wire logic [ADDR_WIDTH-1:0]  req_addr_i,
  input  wire logic [WAY_WIDTH-1:0]   req_way_i,
  input  wire logic [DATA_WIDTH-1:0]  req_data_i,
  input  wire logic                   cmd_v_i,
  input  wire logic                   cmd_ready_i,
  input  wire mem_op_e                cmd_op_i,
  input  wire logic [ADDR_WIDTH-1:0]  cmd_addr_i,
  input  wire logic [WAY_WIDTH-1:0]   cmd_way_i,
  input  wire logic [DATA_WIDTH-1:0]  cmd_data_i,
  input  wire logic                   resp_v_i,
  input  wire logic                   resp_yumi_i,
  input  wire logic                   dpkt_v_i,
  input  wire logic [INDEX_WIDTH-1:0] dpkt_index_i,
  input  wire logic [WAY_WIDTH-1:0]   dpkt_way_i,
  input  wire logic [BEAT_WIDTH-1:0]  dpkt_beat_i,
  input  wire logic [DATA_WIDTH-1:0]  dpkt_data_i,
  input  wire logic                   dpkt_yumi_i,
  input  wire logic [INDEX_WIDTH-1:0] tpkt_index_i,
  input  wire logic [WAY_WIDTH-1:0]   tpkt_way_i,
  input  wire logic [TAG_WIDTH-1:0]   tpkt_tag_i,
  input  wire logic                   tpkt_yumi_i,
  input  wire logic                   critical_i,
  input  wire logic                   complete_i,
  input  wire logic [DATA_WIDTH-1:0]  uc_data_i,
  input  wire logic                   credits_full_i,
  input  wire logic                   credits_empty_i,
  output int                          error_count_o,
  output int                          check_count_o
);

  logic                  active_r;
  req_type_e             type_r;
  logic [ADDR_WIDTH-1:0] addr_r;
  logic [WAY_WIDTH-1:0]  way_r;
  logic [DATA_WIDTH-1:0] data_r;
  logic [ADDR_WIDTH-1:0] fill_addr;
  int                    cmd_idx;
  int                    fill_idx;
  int                    outstanding;

  // words written by completed uncached stores, by word address
  logic [DATA_WIDTH-1:0] store_shadow [logic [ADDR_WIDTH-3:0]];

  // beats of a miss start at the critical word and wrap around the block
  function automatic logic [BEAT_WIDTH-1:0] expected_beat(input logic [ADDR_WIDTH-1:0] addr,
                                                          input int k);
    return BEAT_WIDTH'((int'(addr[OFFSET_WIDTH-1 -: BEAT_WIDTH]) + k) % BLOCK_BEATS);
  endfunction

  function automatic logic [DATA_WIDTH-1:0] expected_word(input logic [ADDR_WIDTH-1:0] addr);
    if (store_shadow.exists(addr[ADDR_WIDTH-1:2]))
      return store_shadow[addr[ADDR_WIDTH-1:2]];
    return {addr ^ 16'h9e37, ~addr};
  endfunction

  task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] expected,
                             input logic [DATA_WIDTH-1:0] actual);
    check_count_o++;
    if (actual !== expected)
    begin
      error_count_o++;
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    error_count_o++;
    $display("[ERROR] %s", what);
  endtask

  always @(posedge clk_i)
  begin
    if (reset_i)
    begin
      active_r    = 1'b0;
      outstanding = 0;
    end
    else
    begin
      // credit flags follow the count of commands not yet answered
      if (outstanding > MAX_CREDITS)
        report_failure("more memory commands outstanding than credits allow");
      check_value("credits_full", outstanding == MAX_CREDITS, credits_full_i);
      check_value("credits_empty", outstanding == 0, credits_empty_i);

      if (cmd_v_i && cmd_ready_i)
      begin
        if (!active_r)
          report_failure("memory command sent with no request in progress");
        else if (type_r == e_miss_load)
        begin
          if (cmd_idx >= BLOCK_BEATS)
            report_failure("miss load sent more commands than beats in a block");
          check_value("miss_cmd_op", e_mem_rd, cmd_op_i);
          check_value("miss_cmd_addr",
                      {addr_r[ADDR_WIDTH-1:OFFSET_WIDTH], expected_beat(addr_r, cmd_idx), 2'b00},
                      cmd_addr_i);
          check_value("cmd_way", way_r, cmd_way_i);
        end
        else
        begin
          if (cmd_idx >= 1)
            report_failure("uncached access sent more than one command");
          check_value("uc_cmd_op", (type_r == e_uc_load) ? e_mem_uc_rd : e_mem_uc_wr, cmd_op_i);
          check_value("uc_cmd_addr", addr_r, cmd_addr_i);
          check_value("cmd_way", way_r, cmd_way_i);
          if (type_r == e_uc_store)
            check_value("uc_cmd_data", data_r, cmd_data_i);
        end
        cmd_idx++;
        outstanding++;
      end

      if (resp_v_i && resp_yumi_i)
      begin
        if (outstanding == 0)
          report_failure("memory response accepted with no command outstanding");
        outstanding--;
      end

      if (dpkt_v_i && dpkt_yumi_i && tpkt_yumi_i)
      begin
        if (!active_r || type_r != e_miss_load || fill_idx >= BLOCK_BEATS)
          report_failure("fill write outside a miss load");
        else
        begin
          fill_addr = {addr_r[ADDR_WIDTH-1:OFFSET_WIDTH], expected_beat(addr_r, fill_idx), 2'b00};
          check_value("fill_beat", expected_beat(addr_r, fill_idx), dpkt_beat_i);
          check_value("fill_data_index", addr_r[OFFSET_WIDTH +: INDEX_WIDTH], dpkt_index_i);
          check_value("fill_tag_index", addr_r[OFFSET_WIDTH +: INDEX_WIDTH], tpkt_index_i);
          check_value("fill_data_way", way_r, dpkt_way_i);
          check_value("fill_tag_way", way_r, tpkt_way_i);
          check_value("fill_tag", addr_r[ADDR_WIDTH-1 -: TAG_WIDTH], tpkt_tag_i);
          check_value("fill_data", expected_word(fill_addr), dpkt_data_i);
          check_value("critical", fill_idx == 0, critical_i);
          fill_idx++;
        end
      end
      else if (critical_i)
        report_failure("critical raised without a fill write");

      if (complete_i)
      begin
        if (!active_r)
          report_failure("complete pulsed with no request in progress");
        else
        begin
          check_value("cmd_count", (type_r == e_miss_load) ? BLOCK_BEATS : 1, cmd_idx);
          if (type_r == e_miss_load)
            check_value("miss_complete_beats", BLOCK_BEATS, fill_idx);
          else if (type_r == e_uc_load)
            check_value("uc_load_data", expected_word(addr_r), uc_data_i);
          else
            store_shadow[addr_r[ADDR_WIDTH-1:2]] = data_r;
          active_r = 1'b0;
        end
      end

      if (req_yumi_i)
      begin
        if (active_r)
          report_failure("request accepted before the previous one completed");
        active_r = 1'b1;
        type_r   = req_type_i;
        addr_r   = req_addr_i;
        way_r    = req_way_i;
        data_r   = req_data_i;
        cmd_idx  = 0;
        fill_idx = 0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/uce_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module uce_sva
  import uce_pkg::*;
(
  input wire logic                  clk_i,
  input wire logic                  reset_i,
  input wire logic                  cmd_v_i,
  input wire logic                  cmd_ready_i,
  input wire mem_op_e               cmd_op_i,
  input wire logic [ADDR_WIDTH-1:0] cmd_addr_i,
  input wire logic [WAY_WIDTH-1:0]  cmd_way_i,
  input wire logic [DATA_WIDTH-1:0] cmd_data_i,
  input wire logic                  credits_full_i,
  input wire logic                  data_pkt_v_i,
  input wire logic                  tag_pkt_v_i,
  input wire logic                  complete_i,
  input wire logic                  busy_i
);

  int failure_count = 0;

  // a stalled command keeps its valid and its fields until memory takes it
  assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_v_i && !cmd_ready_i
    |=> cmd_v_i && $stable({cmd_op_i, cmd_addr_i, cmd_way_i, cmd_data_i}))
    else
    begin
      $error("memory command changed while stalled");
      failure_count++;
    end

  assert property (@(posedge clk_i) disable iff (reset_i)
    credits_full_i |-> !cmd_v_i)
    else
    begin
      $error("memory command valid while credits are full");
      failure_count++;
    end

  assert property (@(posedge clk_i) disable iff (reset_i)
    data_pkt_v_i == tag_pkt_v_i)
    else
    begin
      $error("data and tag write valids differ");
      failure_count++;
    end

  // busy is low only in the ready state
  assert property (@(posedge clk_i) disable iff (reset_i)
    complete_i |-> busy_i)
    else
    begin
      $error("complete raised while the issuer is ready");
      failure_count++;
    end

endmodule

bind uce_top uce_sva uce_sva_inst (
  .clk_i          (clk_i),
  .reset_i        (reset_i),
  .cmd_v_i        (mem_cmd_v_o),
  .cmd_ready_i    (mem_cmd_ready_i),
  .cmd_op_i       (mem_cmd_op_o),
  .cmd_addr_i     (mem_cmd_addr_o),
  .cmd_way_i      (mem_cmd_way_o),
  .cmd_data_i     (mem_cmd_data_o),
  .credits_full_i (cache_req_credits_full_o),
  .data_pkt_v_i   (data_mem_pkt_v_o),
  .tag_pkt_v_i    (tag_mem_pkt_v_o),
  .complete_i     (cache_req_complete_o),
  .busy_i         (cache_req_busy_o)
);

`default_nettype wire

// ==== src/uce_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uce_top
  import uce_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   reset_i,

  input  wire logic                   cache_req_v_i,
  input  wire req_type_e              cache_req_type_i,
  input  wire logic [ADDR_WIDTH-1:0]  cache_req_addr_i,
  input  wire logic [WAY_WIDTH-1:0]   cache_req_way_i,
  input  wire logic [DATA_WIDTH-1:0]  cache_req_data_i,
  output logic                        cache_req_yumi_o,
  output logic                        cache_req_busy_o,
  output logic                        cache_req_complete_o,
  output logic                        cache_req_critical_o,
  output logic                        cache_req_credits_full_o,
  output logic                        cache_req_credits_empty_o,
  output logic [DATA_WIDTH-1:0]       cache_req_uc_data_o,

  output logic                        mem_cmd_v_o,
  output mem_op_e                     mem_cmd_op_o,
  output logic [ADDR_WIDTH-1:0]       mem_cmd_addr_o,
  output logic [WAY_WIDTH-1:0]        mem_cmd_way_o,
  output logic [DATA_WIDTH-1:0]       mem_cmd_data_o,
  input  wire logic                   mem_cmd_ready_i,

  input  wire logic                   mem_resp_v_i,
  input  wire mem_op_e                mem_resp_op_i,
  input  wire logic [ADDR_WIDTH-1:0]  mem_resp_addr_i,
  input  wire logic [WAY_WIDTH-1:0]   mem_resp_way_i,
  input  wire logic [DATA_WIDTH-1:0]  mem_resp_data_i,
  output logic                        mem_resp_yumi_o,

  output logic                        data_mem_pkt_v_o,
  output logic [INDEX_WIDTH-1:0]      data_mem_pkt_index_o,
  output logic [WAY_WIDTH-1:0]        data_mem_pkt_way_o,
  output logic [BEAT_WIDTH-1:0]       data_mem_pkt_beat_o,
  output logic [DATA_WIDTH-1:0]       data_mem_pkt_data_o,
  input  wire logic                   data_mem_pkt_yumi_i,

  output logic                        tag_mem_pkt_v_o,
  output logic [INDEX_WIDTH-1:0]      tag_mem_pkt_index_o,
  output logic [WAY_WIDTH-1:0]        tag_mem_pkt_way_o,
  output logic [TAG_WIDTH-1:0]        tag_mem_pkt_tag_o,
  input  wire logic                   tag_mem_pkt_yumi_i
);

  logic                  fifo_v;
  mem_op_e               fifo_op;
  logic [ADDR_WIDTH-1:0] fifo_addr;
  logic [WAY_WIDTH-1:0]  fifo_way;
  logic [DATA_WIDTH-1:0] fifo_data;
  logic                  fifo_yumi;

  logic req_complete;

  assign cache_req_complete_o = req_complete;

  uce_req_issuer uce_req_issuer_inst (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .cache_req_v_i    (cache_req_v_i),
    .cache_req_type_i (cache_req_type_i),
    .cache_req_addr_i (cache_req_addr_i),
    .cache_req_way_i  (cache_req_way_i),
    .cache_req_data_i (cache_req_data_i),
    .cache_req_yumi_o (cache_req_yumi_o),
    .cache_req_busy_o (cache_req_busy_o),
    .mem_cmd_v_o      (mem_cmd_v_o),
    .mem_cmd_op_o     (mem_cmd_op_o),
    .mem_cmd_addr_o   (mem_cmd_addr_o),
    .mem_cmd_way_o    (mem_cmd_way_o),
    .mem_cmd_data_o   (mem_cmd_data_o),
    .mem_cmd_ready_i  (mem_cmd_ready_i),
    .credit_return_i  (mem_resp_yumi_o),
    .req_complete_i   (req_complete),
    .credits_full_o   (cache_req_credits_full_o),
    .credits_empty_o  (cache_req_credits_empty_o)
  );

  // every accepted response gives back one credit
  uce_resp_fifo uce_resp_fifo_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (mem_resp_v_i),
    .op_i    (mem_resp_op_i),
    .addr_i  (mem_resp_addr_i),
    .way_i   (mem_resp_way_i),
    .data_i  (mem_resp_data_i),
    .ready_o (mem_resp_yumi_o),
    .v_o     (fifo_v),
    .op_o    (fifo_op),
    .addr_o  (fifo_addr),
    .way_o   (fifo_way),
    .data_o  (fifo_data),
    .yumi_i  (fifo_yumi)
  );

  uce_fill_writer uce_fill_writer_inst (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .v_i                  (fifo_v),
    .op_i                 (fifo_op),
    .addr_i               (fifo_addr),
    .way_i                (fifo_way),
    .data_i               (fifo_data),
    .yumi_o               (fifo_yumi),
    .data_mem_pkt_v_o     (data_mem_pkt_v_o),
    .data_mem_pkt_index_o (data_mem_pkt_index_o),
    .data_mem_pkt_way_o   (data_mem_pkt_way_o),
    .data_mem_pkt_beat_o  (data_mem_pkt_beat_o),
    .data_mem_pkt_data_o  (data_mem_pkt_data_o),
    .data_mem_pkt_yumi_i  (data_mem_pkt_yumi_i),
    .tag_mem_pkt_v_o      (tag_mem_pkt_v_o),
    .tag_mem_pkt_index_o  (tag_mem_pkt_index_o),
    .tag_mem_pkt_way_o    (tag_mem_pkt_way_o),
    .tag_mem_pkt_tag_o    (tag_mem_pkt_tag_o),
    .tag_mem_pkt_yumi_i   (tag_mem_pkt_yumi_i),
    .uc_data_o            (cache_req_uc_data_o),
    .critical_o           (cache_req_critical_o),
    .complete_o           (req_complete)
  );

endmodule

`default_nettype wire

// ==== src/uce_fill_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module uce_fill_writer
  import uce_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   reset_i,

  input  wire logic                   v_i,
  input  wire mem_op_e                op_i,
  input  wire logic [ADDR_WIDTH-1:0]  addr_i,
  input  wire logic [WAY_WIDTH-1:0]   way_i,
  input  wire logic [DATA_WIDTH-1:0]  data_i,
  output logic                        yumi_o,

  output logic                        data_mem_pkt_v_o,
  output logic [INDEX_WIDTH-1:0]      data_mem_pkt_index_o,
  output logic [WAY_WIDTH-1:0]        data_mem_pkt_way_o,
  output logic [BEAT_WIDTH-1:0]       data_mem_pkt_beat_o,
  output logic [DATA_WIDTH-1:0]       data_mem_pkt_data_o,
  input  wire logic                   data_mem_pkt_yumi_i,

  output logic                        tag_mem_pkt_v_o,
  output logic [INDEX_WIDTH-1:0]      tag_mem_pkt_index_o,
  output logic [WAY_WIDTH-1:0]        tag_mem_pkt_way_o,
  output logic [TAG_WIDTH-1:0]        tag_mem_pkt_tag_o,
  input  wire logic                   tag_mem_pkt_yumi_i,

  output logic [DATA_WIDTH-1:0]       uc_data_o,
  output logic                        critical_o,
  output logic                        complete_o
);

  logic [BEAT_WIDTH-1:0]  fill_cnt_r;
  logic                   first_beat_r;

  logic [INDEX_WIDTH-1:0] resp_index;
  logic                   fill_v;
  logic                   fill_done;
  logic                   fill_last;
  logic                   uc_done;

  assign resp_index = addr_i[OFFSET_WIDTH +: INDEX_WIDTH];

  assign fill_v    = v_i & (op_i == e_mem_rd);
  // both memories must take the beat in the same cycle
  assign fill_done = fill_v & data_mem_pkt_yumi_i & tag_mem_pkt_yumi_i;
  assign fill_last = (fill_cnt_r == BEAT_WIDTH'(BLOCK_BEATS - 1));

  // uncached responses need nothing from the cache memories
  assign uc_done = v_i & ((op_i == e_mem_uc_rd) | (op_i == e_mem_uc_wr));

  assign data_mem_pkt_v_o     = fill_v;
  assign data_mem_pkt_index_o = resp_index;
  assign data_mem_pkt_way_o   = way_i;
  assign data_mem_pkt_beat_o  = addr_i[OFFSET_WIDTH-1 -: BEAT_WIDTH];
  assign data_mem_pkt_data_o  = data_i;

  assign tag_mem_pkt_v_o     = fill_v;
  assign tag_mem_pkt_index_o = resp_index;
  assign tag_mem_pkt_way_o   = way_i;
  assign tag_mem_pkt_tag_o   = addr_i[ADDR_WIDTH-1 -: TAG_WIDTH];

  assign uc_data_o = data_i;

  assign yumi_o     = fill_done | uc_done;
  assign critical_o = fill_done & first_beat_r;
  assign complete_o = (fill_done & fill_last) | uc_done;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      fill_cnt_r   <= '0;
      first_beat_r <= 1'b1;
    end
    else if (fill_done)
    begin
      // the count wraps to zero on the last beat of the block
      fill_cnt_r   <= fill_cnt_r + 1'b1;
      first_beat_r <= fill_last;
    end
  end

endmodule

`default_nettype wire

// ==== src/uce_resp_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module uce_resp_fifo
  import uce_pkg::*;
(
  input  wire logic                  clk_i,
  input  wire logic                  reset_i,

  input  wire logic                  v_i,
  input  wire mem_op_e               op_i,
  input  wire logic [ADDR_WIDTH-1:0] addr_i,
  input  wire logic [WAY_WIDTH-1:0]  way_i,
  input  wire logic [DATA_WIDTH-1:0] data_i,
  output logic                       ready_o,

  output logic                       v_o,
  output mem_op_e                    op_o,
  output logic [ADDR_WIDTH-1:0]      addr_o,
  output logic [WAY_WIDTH-1:0]       way_o,
  output logic [DATA_WIDTH-1:0]      data_o,
  input  wire logic                  yumi_i
);

  mem_op_e               op_mem   [2];
  logic [ADDR_WIDTH-1:0] addr_mem [2];
  logic [WAY_WIDTH-1:0]  way_mem  [2];
  logic [DATA_WIDTH-1:0] data_mem [2];

  logic       wr_ptr_r;
  logic       rd_ptr_r;
  logic [1:0] count_r;

  // ready_o marks a taken push, so it also serves as the credit return
  assign ready_o = v_i & (count_r != 2'd2);
  assign v_o     = (count_r != 2'd0);

  assign op_o   = op_mem[rd_ptr_r];
  assign addr_o = addr_mem[rd_ptr_r];
  assign way_o  = way_mem[rd_ptr_r];
  assign data_o = data_mem[rd_ptr_r];

  always_ff @(posedge clk_i)
  begin
    if (ready_o)
    begin
      op_mem[wr_ptr_r]   <= op_i;
      addr_mem[wr_ptr_r] <= addr_i;
      way_mem[wr_ptr_r]  <= way_i;
      data_mem[wr_ptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end
    else
    begin
      if (ready_o)
        wr_ptr_r <= ~wr_ptr_r;
      if (yumi_i)
        rd_ptr_r <= ~rd_ptr_r;
      count_r <= count_r + 2'(ready_o) - 2'(yumi_i);
    end
  end

endmodule

`default_nettype wire

// ==== src/uce_req_issuer.sv ====
`timescale 1ns/1ps
`default_nettype none

module uce_req_issuer
  import uce_pkg::*;
(
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,

  input  wire logic                    cache_req_v_i,
  input  wire req_type_e               cache_req_type_i,
  input  wire logic [ADDR_WIDTH-1:0]   cache_req_addr_i,
  input  wire logic [WAY_WIDTH-1:0]    cache_req_way_i,
  input  wire logic [DATA_WIDTH-1:0]   cache_req_data_i,
  output logic                         cache_req_yumi_o,
  output logic                         cache_req_busy_o,

  output logic                         mem_cmd_v_o,
  output mem_op_e                      mem_cmd_op_o,
  output logic [ADDR_WIDTH-1:0]        mem_cmd_addr_o,
  output logic [WAY_WIDTH-1:0]         mem_cmd_way_o,
  output logic [DATA_WIDTH-1:0]        mem_cmd_data_o,
  input  wire logic                    mem_cmd_ready_i,

  input  wire logic                    credit_return_i,
  input  wire logic                    req_complete_i,
  output logic                         credits_full_o,
  output logic                         credits_empty_o
);

  issuer_state_e state_r;

  req_type_e             req_type_r;
  logic [ADDR_WIDTH-1:0] req_addr_r;
  logic [WAY_WIDTH-1:0]  req_way_r;
  logic [DATA_WIDTH-1:0] req_data_r;

  logic [BEAT_WIDTH-1:0]   beat_r;
  logic [BEAT_WIDTH-1:0]   cmd_cnt_r;
  logic [CREDIT_WIDTH-1:0] credit_cnt_r;

  logic cmd_xfer;
  logic last_cmd;

  assign credits_full_o  = (credit_cnt_r == CREDIT_WIDTH'(MAX_CREDITS));
  assign credits_empty_o = (credit_cnt_r == '0);

  assign cache_req_yumi_o = (state_r == e_ready) & cache_req_v_i & ~credits_full_o;
  assign cache_req_busy_o = (state_r != e_ready);

  // the count only grows on a transfer, so a raised valid cannot meet a full count
  assign mem_cmd_v_o = (state_r == e_send) & ~credits_full_o;
  assign cmd_xfer    = mem_cmd_v_o & mem_cmd_ready_i;

  assign last_cmd = (req_type_r != e_miss_load) | (cmd_cnt_r == BEAT_WIDTH'(BLOCK_BEATS - 1));

  always_comb
  begin
    unique case (req_type_r)
      e_miss_load: mem_cmd_op_o = e_mem_rd;
      e_uc_load:   mem_cmd_op_o = e_mem_uc_rd;
      default:     mem_cmd_op_o = e_mem_uc_wr;
    endcase
  end

  // miss beats walk the block from the critical word and wrap around
  assign mem_cmd_addr_o = (req_type_r == e_miss_load)
                        ? {req_addr_r[ADDR_WIDTH-1:OFFSET_WIDTH], beat_r,
                           {(OFFSET_WIDTH - BEAT_WIDTH){1'b0}}}
                        : req_addr_r;
  assign mem_cmd_way_o  = req_way_r;
  assign mem_cmd_data_o = req_data_r;

  always_ff @(posedge clk_i)
  begin
    if (cache_req_yumi_o)
    begin
      req_type_r <= cache_req_type_i;
      req_addr_r <= cache_req_addr_i;
      req_way_r  <= cache_req_way_i;
      req_data_r <= cache_req_data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r   <= e_ready;
      beat_r    <= '0;
      cmd_cnt_r <= '0;
    end
    else
    begin
      unique case (state_r)
        e_ready:
        begin
          if (cache_req_yumi_o)
          begin
            state_r   <= e_send;
            beat_r    <= cache_req_addr_i[OFFSET_WIDTH-1 -: BEAT_WIDTH];
            cmd_cnt_r <= '0;
          end
        end
        e_send:
        begin
          if (cmd_xfer)
          begin
            beat_r    <= beat_r + 1'b1;
            cmd_cnt_r <= cmd_cnt_r + 1'b1;
            if (last_cmd)
              state_r <= e_wait;
          end
        end
        default:
        begin
          if (req_complete_i)
            state_r <= e_ready;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      credit_cnt_r <= '0;
    else if (cmd_xfer & ~credit_return_i)
      credit_cnt_r <= credit_cnt_r + 1'b1;
    else if (~cmd_xfer & credit_return_i)
      credit_cnt_r <= credit_cnt_r - 1'b1;
  end

endmodule

`default_nettype wire

// ==== src/uce_pkg.sv ====
`default_nettype none

package uce_pkg;

  // physical byte address
  localparam int ADDR_WIDTH   = 16;

  // one fill beat or one uncached word
  localparam int DATA_WIDTH   = 32;

  // a 16 byte block moves as four 32 bit beats
  localparam int BLOCK_BEATS  = 4;
  localparam int BEAT_WIDTH   = $clog2(BLOCK_BEATS);
  localparam int OFFSET_WIDTH = 4;

  // 16 sets, 2 ways
  localparam int INDEX_WIDTH  = 4;
  localparam int WAY_WIDTH    = 1;
  localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

  // outstanding memory commands
  localparam int MAX_CREDITS  = 4;
  localparam int CREDIT_WIDTH = $clog2(MAX_CREDITS + 1);

  typedef enum logic [1:0] {
    e_miss_load = 2'b00,
    e_uc_load   = 2'b01,
    e_uc_store  = 2'b10
  } req_type_e;

  // e_mem_rd fetches one beat of a block
  typedef enum logic [1:0] {
    e_mem_rd    = 2'b00,
    e_mem_uc_rd = 2'b01,
    e_mem_uc_wr = 2'b10
  } mem_op_e;

  typedef enum logic [1:0] {
    e_ready = 2'b00,
    e_send  = 2'b01,
    e_wait  = 2'b10
  } issuer_state_e;

endpackage

`default_nettype wire
